// ==== verification/video_cases.txt ====
# case l0_scroll_x l0_scroll_y l1_scroll_x l1_scroll_y bg_index
#   then three samples of x y expected_index
1 0 0 0 0 5 0 0 9 16 8 3 56 8 9
2 0 0 56 0 3 0 0 3 100 50 2 287 223 6
3 500 250 7 3 10 0 0 5 20 10 1 12 6 12
4 0 0 0 0 7 0 0 9 8 0 1 100 50 2

// ==== build.f ====
design/video_pkg.sv
design/raster_timing.sv
design/layer_scanner.sv
design/pixel_fifo.sv
design/priority_mixer.sv
design/video_top.sv
verification/video_checker.sv
verification/video_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing -j 0 -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP       = video_tb
FILELIST  = build.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/video_tb.sv ====
`timescale 1ns/1ps

module video_tb;
	import video_pkg::*;

	// a frame is 811008 cycles
	localparam int wait_limit = 1000000;

	logic                        CLK_48M = 1'b0;
	logic                        rst_n;
	logic                        scroll_we;
	logic [layer_sel_w-1:0]      scroll_layer;
	logic                        scroll_axis;
	logic [scroll_x_w-1:0]       scroll_data;
	logic [index_w-1:0]          bg_index;
	logic [index_w-1:0]          pixel_index;
	logic                        out_hsync_n;
	logic                        out_vsync_n;
	logic                        out_hblank_n;
	logic                        out_vblank_n;
	logic                        out_pix_en;
	logic                        case_load;
	int                          case_num;
	logic [2:0][cnt_w-1:0]       samp_x;
	logic [2:0][cnt_w-1:0]       samp_y;
	logic [2:0][index_w-1:0]     samp_exp;
	int                          pass_count;
	int                          fail_count;

	// 40 ns period
	always #20 CLK_48M = ~CLK_48M;

	video_top uut (
		.CLK_48M      (CLK_48M),
		.rst_n        (rst_n),
		.scroll_we    (scroll_we),
		.scroll_layer (scroll_layer),
		.scroll_axis  (scroll_axis),
		.scroll_data  (scroll_data),
		.bg_index     (bg_index),
		.pixel_index  (pixel_index),
		.out_hsync_n  (out_hsync_n),
		.out_vsync_n  (out_vsync_n),
		.out_hblank_n (out_hblank_n),
		.out_vblank_n (out_vblank_n),
		.out_pix_en   (out_pix_en)
	);

	video_checker u_checker (
		.CLK_48M      (CLK_48M),
		.rst_n        (rst_n),
		.pixel_index  (pixel_index),
		.out_hsync_n  (out_hsync_n),
		.out_vsync_n  (out_vsync_n),
		.out_hblank_n (out_hblank_n),
		.out_vblank_n (out_vblank_n),
		.out_pix_en   (out_pix_en),
		.case_load    (case_load),
		.case_num     (case_num),
		.samp_x       (samp_x),
		.samp_y       (samp_y),
		.samp_exp     (samp_exp),
		.pass_count   (pass_count),
		.fail_count   (fail_count)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// wait for an edge of out_vblank_n, bounded
	task automatic wait_vblank(input logic rising);
		int   n;
		logic prev;
		logic found;
		n = 0;
		found = 1'b0;
		prev = out_vblank_n;
		while (!found && n < wait_limit) begin
			@(posedge CLK_48M);
			n++;
			if (out_vblank_n == rising && prev != rising) found = 1'b1;
			prev = out_vblank_n;
		end
		if (!found) begin
			$display("timeout: no vertical blank edge within %0d cycles", wait_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	endtask

	// wait for the next output strobe, bounded
	task automatic wait_strobe();
		int   n;
		logic found;
		n = 0;
		found = 1'b0;
		while (!found && n < wait_limit) begin
			@(posedge CLK_48M);
			n++;
			if (out_pix_en == 1'b1) found = 1'b1;
		end
		if (!found) begin
			$display("timeout: no pixel strobe within %0d cycles", wait_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	endtask

	// one shadow register write
	task automatic write_scroll(input int layer, input int axis, input int value);
		@(posedge CLK_48M);
		scroll_we <= 1'b1;
		scroll_layer <= layer_sel_w'(layer);
		scroll_axis <= axis[0];
		scroll_data <= scroll_x_w'(value);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int    fd;
		int    n;
		int    c;
		int    sc [4];
		int    bg;
		int    sx [3];
		int    sy [3];
		int    se [3];
		string line;
		rst_n = 1'b0;
		scroll_we = 1'b0;
		scroll_layer = '0;
		scroll_axis = 1'b0;
		scroll_data = '0;
		bg_index = '0;
		case_load = 1'b0;
		case_num = 0;
		samp_x = '0;
		samp_y = '0;
		samp_exp = '0;
		fd = $fopen("verification/video_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/video_cases.txt");
			$display("CHECKS FAILED");
			$finish;
		end
		repeat (10) @(posedge CLK_48M);
		rst_n <= 1'b1;
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
				n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
					c, sc[0], sc[1], sc[2], sc[3], bg,
					sx[0], sy[0], se[0], sx[1], sy[1], se[1], sx[2], sy[2], se[2]);
				if (n == 15) begin
					// writes land early in a running frame
					wait_vblank(1'b1);
					write_scroll(0, 0, sc[0]);
					write_scroll(0, 1, sc[1]);
					write_scroll(1, 0, sc[2]);
					write_scroll(1, 1, sc[3]);
					@(posedge CLK_48M);
					scroll_we <= 1'b0;
					// old samples still hold for this frame
					wait_vblank(1'b0);
					bg_index <= index_w'(bg);
					case_num <= c;
					for (int k = 0; k < 3; k++) begin
						samp_x[k] <= cnt_w'(sx[k]);
						samp_y[k] <= cnt_w'(sy[k]);
						samp_exp[k] <= index_w'(se[k]);
					end
					case_load <= 1'b1;
					@(posedge CLK_48M);
					case_load <= 1'b0;
					// the frame with the new values
					wait_vblank(1'b0);
				end
			end
		end
		$fclose(fd);
		// first strobe of vertical blank closes the last frame
		wait_strobe();
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count > 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/video_checker.sv ====
`timescale 1ns/1ps

module video_checker (
	input  logic                                  CLK_48M,
	input  logic                                  rst_n,
	input  logic [video_pkg::index_w-1:0]         pixel_index,
	input  logic                                  out_hsync_n,
	input  logic                                  out_vsync_n,
	input  logic                                  out_hblank_n,
	input  logic                                  out_vblank_n,
	input  logic                                  out_pix_en,
	input  logic                                  case_load,
	input  int                                    case_num,
	input  logic [2:0][video_pkg::cnt_w-1:0]      samp_x,
	input  logic [2:0][video_pkg::cnt_w-1:0]      samp_y,
	input  logic [2:0][video_pkg::index_w-1:0]    samp_exp,
	output int                                    pass_count,
	output int                                    fail_count
);
	import video_pkg::*;

	int                      x = 0;
	int                      y = 0;
	int                      gap = 0;
	int                      frame_no = 0;
	int                      frame_err = 0;
	int                      reset_err = 0;
	int                      passes = 0;
	int                      fails = 0;
	int                      cur_case = 0;
	bit                      have_prev = 0;
	bit                      in_reset = 0;
	logic [2:0][cnt_w-1:0]   cur_x = '0;
	logic [2:0][cnt_w-1:0]   cur_y = '0;
	logic [2:0][index_w-1:0] cur_exp = '0;
	bit                      cur_valid = 0;

	assign pass_count = passes;
	assign fail_count = fails;

	// one output level against its expected value
	task automatic check_level(input string what, input logic got, input logic want);
		if (got !== want) begin
			$display("Error %0t: %s is %b at x=%0d y=%0d, expected %b",
				$time, what, got, x, y, want);
			frame_err++;
		end
	endtask

	// one line per frame
	task automatic close_frame();
		if (frame_err == 0) begin
			$display("frame %0d (case %0d): pass", frame_no, cur_case);
			passes++;
		end else begin
			$display("frame %0d (case %0d): fail, %0d errors", frame_no, cur_case, frame_err);
			fails++;
		end
		frame_no++;
		frame_err = 0;
	endtask

	////////////////////////////////////////
	// sampling on the falling edge
	////////////////////////////////////////

	always @(negedge CLK_48M) begin
		if (!rst_n) begin
			// reset values, all outputs inactive
			in_reset = 1;
			x = 0;
			y = 0;
			gap = 0;
			have_prev = 0;
			if (out_hsync_n !== 1'b1 || out_vsync_n !== 1'b1 || out_hblank_n !== 1'b1 ||
				out_vblank_n !== 1'b1 || out_pix_en !== 1'b0 || pixel_index !== '0) begin
				$display("Error %0t: outputs not in reset state", $time);
				reset_err++;
			end
		end else begin
			if (in_reset) begin
				in_reset = 0;
				// first cycle out of reset, still inactive and no strobe yet
				if (out_hsync_n !== 1'b1 || out_vsync_n !== 1'b1 || out_hblank_n !== 1'b1 ||
					out_vblank_n !== 1'b1 || out_pix_en !== 1'b0 || pixel_index !== '0) begin
					$display("Error %0t: outputs not inactive right after reset", $time);
					reset_err++;
				end
				if (reset_err == 0) begin
					$display("reset state: pass");
					passes++;
				end else begin
					$display("reset state: fail, %0d errors", reset_err);
					fails++;
				end
			end
			if (case_load) begin
				cur_x = samp_x;
				cur_y = samp_y;
				cur_exp = samp_exp;
				cur_case = case_num;
				cur_valid = 1;
			end
			gap++;
			if (out_pix_en) begin
				// strobe spacing is the pixel divider
				if (have_prev && gap != pix_div) begin
					$display("Error %0t: %0d cycles between strobes, expected %0d",
						$time, gap, pix_div);
					frame_err++;
				end
				gap = 0;
				have_prev = 1;
				// start of vertical blank ends a frame test
				if (x == 0 && y == v_active) close_frame();
				check_level("out_hsync_n", out_hsync_n, !(x >= h_sync_start && x <= h_sync_end));
				check_level("out_vsync_n", out_vsync_n, !(y >= v_sync_start && y <= v_sync_end));
				check_level("out_hblank_n", out_hblank_n, x < h_active);
				check_level("out_vblank_n", out_vblank_n, y < v_active);
				if (!(x < h_active && y < v_active)) begin
					// black during any blank
					if (pixel_index !== '0) begin
						$display("Error %0t: pixel_index %0d in blank at x=%0d y=%0d",
							$time, pixel_index, x, y);
						frame_err++;
					end
				end else if (cur_valid) begin
					for (int k = 0; k < 3; k++) begin
						if (x == int'(cur_x[k]) && y == int'(cur_y[k]) &&
							pixel_index !== cur_exp[k]) begin
							$display("Error %0t: case %0d x=%0d y=%0d pixel_index %0d, expected %0d",
								$time, cur_case, x, y, pixel_index, cur_exp[k]);
							frame_err++;
						end
					end
				end
				// raster position of the next strobe
				if (x == h_total - 1) begin
					x = 0;
					y = (y == v_total - 1) ? 0 : y + 1;
				end else begin
					x++;
				end
			end
		end
	end

endmodule

// ==== design/video_top.sv ====
`timescale 1ns/1ps

module video_top (
	input  logic                              CLK_48M,
	input  logic                              rst_n,
	input  logic                              scroll_we,
	input  logic [video_pkg::layer_sel_w-1:0] scroll_layer,
	input  logic                              scroll_axis,
	input  logic [video_pkg::scroll_x_w-1:0]  scroll_data,
	input  logic [video_pkg::index_w-1:0]     bg_index,
	output logic [video_pkg::index_w-1:0]     pixel_index,
	output logic                              out_hsync_n,
	output logic                              out_vsync_n,
	output logic                              out_hblank_n,
	output logic                              out_vblank_n,
	output logic                              out_pix_en
);
	import video_pkg::*;

	logic                                pix_en;
	logic                                hsync_n;
	logic                                vsync_n;
	logic                                hblank_n;
	logic                                vblank_n;
	logic                                frame_start;
	logic [num_layers-1:0]               push;
	logic [num_layers-1:0][color_w-1:0] pix_color;
	logic [num_layers-1:0]               credit_ret;

	// raw counters stay inside, layers keep their own position
	raster_timing u_timing (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.pix_en      (pix_en),
		.h_count     (),
		.v_count     (),
		.hsync_n     (hsync_n),
		.vsync_n     (vsync_n),
		.hblank_n    (hblank_n),
		.vblank_n    (vblank_n),
		.frame_start (frame_start)
	);

	////////////////////////////////////////
	// tile layers
	////////////////////////////////////////

	for (genvar i = 0; i < num_layers; i++) begin : g_layer
		layer_scanner #(
			.layer_id (i)
		) u_scanner (
			.CLK_48M      (CLK_48M),
			.rst_n        (rst_n),
			.frame_start  (frame_start),
			.scroll_we    (scroll_we),
			.scroll_layer (scroll_layer),
			.scroll_axis  (scroll_axis),
			.scroll_data  (scroll_data),
			.credit_ret   (credit_ret[i]),
			.push         (push[i]),
			.pix_color    (pix_color[i])
		);
	end

	priority_mixer u_mixer (
		.CLK_48M      (CLK_48M),
		.rst_n        (rst_n),
		.pix_en       (pix_en),
		.hsync_n      (hsync_n),
		.vsync_n      (vsync_n),
		.hblank_n     (hblank_n),
		.vblank_n     (vblank_n),
		.frame_start  (frame_start),
		.bg_index     (bg_index),
		.push         (push),
		.pix_color    (pix_color),
		.credit_ret   (credit_ret),
		.pixel_index  (pixel_index),
		.out_hsync_n  (out_hsync_n),
		.out_vsync_n  (out_vsync_n),
		.out_hblank_n (out_hblank_n),
		.out_vblank_n (out_vblank_n),
		.out_pix_en   (out_pix_en)
	);

endmodule

// ==== design/priority_mixer.sv ====
`timescale 1ns/1ps

module priority_mixer (
	input  logic                                                     CLK_48M,
	input  logic                                                     rst_n,
	input  logic                                                     pix_en,
	input  logic                                                     hsync_n,
	input  logic                                                     vsync_n,
	input  logic                                                     hblank_n,
	input  logic                                                     vblank_n,
	input  logic                                                     frame_start,
	input  logic [video_pkg::index_w-1:0]                            bg_index,
	input  logic [video_pkg::num_layers-1:0]                         push,
	input  logic [video_pkg::num_layers-1:0][video_pkg::color_w-1:0] pix_color,
	output logic [video_pkg::num_layers-1:0]                         credit_ret,
	output logic [video_pkg::index_w-1:0]                            pixel_index,
	output logic                                                     out_hsync_n,
	output logic                                                     out_vsync_n,
	output logic                                                     out_hblank_n,
	output logic                                                     out_vblank_n,
	output logic                                                     out_pix_en
);
	import video_pkg::*;

	logic                                active;
	logic                                pop;
	logic [num_layers-1:0][color_w-1:0] head;
	logic [index_w-1:0]                  mix_index;

	assign active = hblank_n && vblank_n;
	assign pop = pix_en && active;

	// one credit back per popped pixel, every layer pops together
	assign credit_ret = {num_layers{pop}};

	////////////////////////////////////////
	// per layer receive fifos
	////////////////////////////////////////

	for (genvar i = 0; i < num_layers; i++) begin : g_fifo
		pixel_fifo u_fifo (
			.CLK_48M (CLK_48M),
			.rst_n   (rst_n),
			.flush   (frame_start),
			.wr      (push[i]),
			.wr_data (pix_color[i]),
			.rd      (pop),
			.rd_data (head[i])
		);
	end

	// scan back to front so layer 0 wins
	always_comb begin
		mix_index = bg_index;
		for (int i = num_layers - 1; i >= 0; i--) begin
			if (head[i] != '0) begin
				// layer n uses palette block n
				mix_index = index_w'(i * (1 << color_w)) + index_w'(head[i]);
			end
		end
	end

	////////////////////////////////////////
	// output stage
	////////////////////////////////////////

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			pixel_index <= '0;
			out_hsync_n <= 1'b1;
			out_vsync_n <= 1'b1;
			out_hblank_n <= 1'b1;
			out_vblank_n <= 1'b1;
			out_pix_en <= 1'b0;
		end else begin
			out_pix_en <= pix_en;
			out_hsync_n <= hsync_n;
			out_vsync_n <= vsync_n;
			out_hblank_n <= hblank_n;
			out_vblank_n <= vblank_n;
			// index held between strobes, black in blank
			if (pix_en) pixel_index <= active ? mix_index : '0;
		end
	end

endmodule

// ==== design/pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo (
	input  logic                          CLK_48M,
	input  logic                          rst_n,
	input  logic                          flush,
	input  logic                          wr,
	input  logic [video_pkg::color_w-1:0] wr_data,
	input  logic                          rd,
	output logic [video_pkg::color_w-1:0] rd_data
);
	import video_pkg::*;

	logic [color_w-1:0]  mem [fifo_depth];
	logic [ptr_w-1:0]    wr_ptr;
	logic [ptr_w-1:0]    rd_ptr;
	logic [credit_w-1:0] count;
	logic                do_wr;
	logic                do_rd;

	assign do_wr = wr && (count != credit_w'(fifo_depth));
	assign do_rd = rd && (count != '0);

	always_ff @(posedge CLK_48M) begin
		if (do_wr) mem[wr_ptr] <= wr_data;
	end

	// flush drops everything, including a same-cycle write
	always_ff @(posedge CLK_48M) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + credit_w'(do_wr) - credit_w'(do_rd);
		end
	end

	// empty reads as transparent
	assign rd_data = (count != '0) ? mem[rd_ptr] : '0;

endmodule

// ==== design/layer_scanner.sv ====
`timescale 1ns/1ps

module layer_scanner #(
	parameter int layer_id = 0
) (
	input  logic                              CLK_48M,
	input  logic                              rst_n,
	input  logic                              frame_start,
	input  logic                              scroll_we,
	input  logic [video_pkg::layer_sel_w-1:0] scroll_layer,
	input  logic                              scroll_axis,
	input  logic [video_pkg::scroll_x_w-1:0]  scroll_data,
	input  logic                              credit_ret,
	output logic                              push,
	output logic [video_pkg::color_w-1:0]     pix_color
);
	import video_pkg::*;

	logic [scroll_x_w-1:0]           shadow_x;
	logic [scroll_y_w-1:0]           shadow_y;
	logic [scroll_x_w-1:0]           scroll_x;
	logic [scroll_y_w-1:0]           scroll_y;
	logic [cnt_w-1:0]                pos_x;
	logic [cnt_w-1:0]                pos_y;
	logic                            done;
	logic [credit_w-1:0]             credits;
	logic                            sel_me;
	logic                            issue;
	logic [scroll_x_w-1:0]           sum_x;
	logic [scroll_y_w-1:0]           sum_y;
	logic [scroll_x_w-tile_bits-1:0] tile_col;
	logic [scroll_y_w-tile_bits-1:0] tile_row;
	logic [color_w-1:0]              color;

	////////////////////////////////////////
	// scroll registers
	////////////////////////////////////////

	assign sel_me = scroll_we && (scroll_layer == layer_sel_w'(layer_id));

	// writes sit in shadow until the frame boundary
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			shadow_x <= '0;
			shadow_y <= '0;
			scroll_x <= '0;
			scroll_y <= '0;
		end else begin
			if (sel_me && !scroll_axis) shadow_x <= scroll_data;
			if (sel_me && scroll_axis) shadow_y <= scroll_data[scroll_y_w-1:0];
			if (frame_start) begin
				scroll_x <= shadow_x;
				scroll_y <= shadow_y;
			end
		end
	end

	// one pixel per cycle while credits last
	assign issue = (credits != '0) && !done && !frame_start;

	// walk the visible area in raster order
	always_ff @(posedge CLK_48M) begin
		if (!rst_n || frame_start) begin
			pos_x <= '0;
			pos_y <= '0;
			done <= 1'b0;
		end else if (issue) begin
			if (pos_x == cnt_w'(h_active - 1)) begin
				pos_x <= '0;
				if (pos_y == cnt_w'(v_active - 1)) done <= 1'b1;
				else pos_y <= pos_y + 1'b1;
			end else begin
				pos_x <= pos_x + 1'b1;
			end
		end
	end

	// credits refill at frame start, mixer fifo is flushed then
	always_ff @(posedge CLK_48M) begin
		if (!rst_n || frame_start) credits <= credit_w'(fifo_depth);
		else credits <= credits - credit_w'(issue) + credit_w'(credit_ret);
	end

	// tile pattern, sums wrap at register width
	assign sum_x = scroll_x_w'(pos_x) + scroll_x;
	assign sum_y = scroll_y_w'(pos_y) + scroll_y;
	assign tile_col = sum_x[scroll_x_w-1:tile_bits];
	assign tile_row = sum_y[scroll_y_w-1:tile_bits];
	// zero is transparent
	assign color = color_w'(tile_col) + color_w'(tile_row) + color_w'(layer_id);

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) push <= 1'b0;
		else push <= issue;
	end

	always_ff @(posedge CLK_48M) begin
		if (issue) pix_color <= color;
	end

endmodule

// ==== design/raster_timing.sv ====
`timescale 1ns/1ps

module raster_timing (
	input  logic                        CLK_48M,
	input  logic                        rst_n,
	output logic                        pix_en,
	output logic [video_pkg::cnt_w-1:0] h_count,
	output logic [video_pkg::cnt_w-1:0] v_count,
	output logic                        hsync_n,
	output logic                        vsync_n,
	output logic                        hblank_n,
	output logic                        vblank_n,
	output logic                        frame_start
);
	import video_pkg::*;

	logic [$clog2(pix_div)-1:0] prescale;
	logic                       h_last;
	logic                       v_last;
	logic                       h_in_sync;
	logic                       v_in_sync;

	////////////////////////////////////////
	// pixel enable
	////////////////////////////////////////

	// free running divider, enable on last step
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			prescale <= '0;
		end else if (prescale == ($clog2(pix_div))'(pix_div - 1)) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	assign pix_en = (prescale == ($clog2(pix_div))'(pix_div - 1));

	////////////////////////////////////////
	// raster counters
	////////////////////////////////////////

	assign h_last = (h_count == cnt_w'(h_total - 1));
	assign v_last = (v_count == cnt_w'(v_total - 1));

	// h counts pixels, only moves on the enable
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			h_count <= '0;
		end else if (pix_en) begin
			if (h_last) begin
				h_count <= '0;
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

	// v steps once per line wrap
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			v_count <= '0;
		end else if (pix_en && h_last) begin
			if (v_last) begin
				v_count <= '0;
			end else begin
				v_count <= v_count + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// sync and blank decode
	////////////////////////////////////////

	// windows are inclusive at both ends
	assign h_in_sync = (h_count >= cnt_w'(h_sync_start)) && (h_count <= cnt_w'(h_sync_end));
	assign v_in_sync = (v_count >= cnt_w'(v_sync_start)) && (v_count <= cnt_w'(v_sync_end));

	assign hsync_n = !h_in_sync;
	assign vsync_n = !v_in_sync;

	// high only inside the visible area
	assign hblank_n = (h_count < cnt_w'(h_active));
	assign vblank_n = (v_count < cnt_w'(v_active));

	// last pixel of the last visible line
	// next enable lands on line v_active, pixel 0
	assign frame_start = pix_en && h_last && (v_count == cnt_w'(v_active - 1));

endmodule

// ==== design/video_pkg.sv ====
package video_pkg;

	////////////////////////////////////////
	// raster geometry
	////////////////////////////////////////

	// 48 MHz down to 6 MHz pixel rate
	localparam int pix_div = 8;

	// horizontal, in pixels
	localparam int h_total = 384;
	localparam int h_active = 288;
	localparam int h_sync_start = 320;
	localparam int h_sync_end = 351;

	// vertical, in lines
	localparam int v_total = 264;
	localparam int v_active = 224;
	localparam int v_sync_start = 232;
	localparam int v_sync_end = 239;

	localparam int cnt_w = 9;

	////////////////////////////////////////
	// layers and pixel path
	////////////////////////////////////////

	localparam int num_layers = 2;
	// select width for the scroll write port
	localparam int layer_sel_w = (num_layers > 1) ? $clog2(num_layers) : 1;

	// fifo entries per layer, also the starting credit count
	localparam int fifo_depth = 4;
	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int credit_w = $clog2(fifo_depth + 1);

	localparam int color_w = 3;
	localparam int index_w = 4;
	localparam int scroll_x_w = 9;
	localparam int scroll_y_w = 8;

	// tiles are 8x8 pixels
	localparam int tile_bits = 3;

endpackage
